/* Makefile */
TOOL     := verilator
FLAGS    := --timing --assert -Wno-fatal
TOP      := tb_cc_complex
FILELIST := build.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || (echo "simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+.
cc_pkg.sv
spill_register.sv
cc_dispatch.sv
cc_ipu.sv
cc_lsu.sv
cc_writeback.sv
cc_complex.sv
cc_complex_properties.sv
tb_cc_checker.sv
tb_cc_complex.sv

/* cc_cfg.svh */
`ifndef CC_CFG_SVH
`define CC_CFG_SVH

// Datapath and id widths
`define CC_DATA_WIDTH 32
`define CC_ID_WIDTH 5

// Outstanding TCDM requests, and words backed by memory
`define CC_LSU_DEPTH 4
`define CC_MEM_WORDS 256

// 1 registers the path, 0 bypasses it
`define CC_REG_ACC_REQ 1
`define CC_REG_ACC_RESP 1
`define CC_REG_TCDM_REQ 0
`define CC_REG_TCDM_RESP 0

`endif

/* cc_complex.sv */
`default_nettype none

`include "cc_cfg.svh"

module cc_complex (
  input  logic                        clk_i,
  input  logic                        rst_i,
  // Operation in
  input  logic [2:0]                  op_op_i,
  input  logic [`CC_ID_WIDTH-1:0]     op_id_i,
  input  logic [`CC_DATA_WIDTH-1:0]   op_arga_i,
  input  logic [`CC_DATA_WIDTH-1:0]   op_argb_i,
  input  logic                        op_valid_i,
  output logic                        op_ready_o,
  // TCDM port
  output logic [`CC_DATA_WIDTH-1:0]   data_qaddr_o,
  output logic                        data_qwrite_o,
  output logic [`CC_DATA_WIDTH-1:0]   data_qdata_o,
  output logic [`CC_DATA_WIDTH/8-1:0] data_qstrb_o,
  output logic                        data_qvalid_o,
  input  logic                        data_qready_i,
  input  logic [`CC_DATA_WIDTH-1:0]   data_pdata_i,
  input  logic                        data_perror_i,
  input  logic                        data_pvalid_i,
  output logic                        data_pready_o,
  // Result out
  output logic [`CC_ID_WIDTH-1:0]     res_id_o,
  output logic [`CC_DATA_WIDTH-1:0]   res_data_o,
  output logic                        res_error_o,
  output logic                        res_valid_o,
  input  logic                        res_ready_i
);

  import cc_pkg::*;

  op_req_t   op_req;
  result_t   result;
  acc_req_t  acc_req_d, acc_req_q;
  acc_resp_t acc_resp_d, acc_resp_q;
  dreq_t     dreq_d, dreq_q;
  dresp_t    dresp_d, dresp_q;

  logic acc_req_d_valid, acc_req_d_ready, acc_req_q_valid, acc_req_q_ready;
  logic acc_resp_d_valid, acc_resp_d_ready, acc_resp_q_valid, acc_resp_q_ready;
  logic dreq_d_valid, dreq_d_ready, dreq_q_valid, dreq_q_ready;
  logic dresp_d_valid, dresp_d_ready, dresp_q_valid, dresp_q_ready;

  assign op_req.op   = op_e'(op_op_i);
  assign op_req.id   = op_id_i;
  assign op_req.arga = op_arga_i;
  assign op_req.argb = op_argb_i;

  cc_dispatch i_dispatch (
    .op_i         ( op_req          ),
    .op_valid_i   ( op_valid_i      ),
    .op_ready_o   ( op_ready_o      ),
    .acc_req_o    ( acc_req_d       ),
    .acc_valid_o  ( acc_req_d_valid ),
    .acc_ready_i  ( acc_req_d_ready ),
    .data_req_o   ( dreq_d          ),
    .data_valid_o ( dreq_d_valid    ),
    .data_ready_i ( dreq_d_ready    )
  );

  // --------------------------------------------------------------------------
  // Offload path
  // --------------------------------------------------------------------------
  spill_register #(
    .T      ( acc_req_t               ),
    .Bypass ( `CC_REG_ACC_REQ == 0    )
  ) i_spill_acc_req (
    .clk_i,
    .rst_i,
    .valid_i ( acc_req_d_valid ),
    .ready_o ( acc_req_d_ready ),
    .data_i  ( acc_req_d       ),
    .valid_o ( acc_req_q_valid ),
    .ready_i ( acc_req_q_ready ),
    .data_o  ( acc_req_q       )
  );

  cc_ipu i_ipu (
    .clk_i,
    .rst_i,
    .acc_req_i   ( acc_req_q        ),
    .acc_valid_i ( acc_req_q_valid  ),
    .acc_ready_o ( acc_req_q_ready  ),
    .acc_resp_o  ( acc_resp_d       ),
    .acc_valid_o ( acc_resp_d_valid ),
    .acc_ready_i ( acc_resp_d_ready )
  );

  spill_register #(
    .T      ( acc_resp_t              ),
    .Bypass ( `CC_REG_ACC_RESP == 0   )
  ) i_spill_acc_resp (
    .clk_i,
    .rst_i,
    .valid_i ( acc_resp_d_valid ),
    .ready_o ( acc_resp_d_ready ),
    .data_i  ( acc_resp_d       ),
    .valid_o ( acc_resp_q_valid ),
    .ready_i ( acc_resp_q_ready ),
    .data_o  ( acc_resp_q       )
  );

  // --------------------------------------------------------------------------
  // Memory path
  // --------------------------------------------------------------------------
  spill_register #(
    .T      ( dreq_t                  ),
    .Bypass ( `CC_REG_TCDM_REQ == 0   )
  ) i_spill_tcdm_req (
    .clk_i,
    .rst_i,
    .valid_i ( dreq_d_valid ),
    .ready_o ( dreq_d_ready ),
    .data_i  ( dreq_d       ),
    .valid_o ( dreq_q_valid ),
    .ready_i ( dreq_q_ready ),
    .data_o  ( dreq_q       )
  );

  cc_lsu i_lsu (
    .clk_i,
    .rst_i,
    .req_i         ( dreq_q        ),
    .req_valid_i   ( dreq_q_valid  ),
    .req_ready_o   ( dreq_q_ready  ),
    .data_qaddr_o,
    .data_qwrite_o,
    .data_qdata_o,
    .data_qstrb_o,
    .data_qvalid_o,
    .data_qready_i,
    .data_pdata_i,
    .data_perror_i,
    .data_pvalid_i,
    .data_pready_o,
    .resp_o        ( dresp_d       ),
    .resp_valid_o  ( dresp_d_valid ),
    .resp_ready_i  ( dresp_d_ready )
  );

  spill_register #(
    .T      ( dresp_t                 ),
    .Bypass ( `CC_REG_TCDM_RESP == 0  )
  ) i_spill_tcdm_resp (
    .clk_i,
    .rst_i,
    .valid_i ( dresp_d_valid ),
    .ready_o ( dresp_d_ready ),
    .data_i  ( dresp_d       ),
    .valid_o ( dresp_q_valid ),
    .ready_i ( dresp_q_ready ),
    .data_o  ( dresp_q       )
  );

  cc_writeback i_writeback (
    .clk_i,
    .rst_i,
    .acc_resp_i   ( acc_resp_q       ),
    .acc_valid_i  ( acc_resp_q_valid ),
    .acc_ready_o  ( acc_resp_q_ready ),
    .data_resp_i  ( dresp_q          ),
    .data_valid_i ( dresp_q_valid    ),
    .data_ready_o ( dresp_q_ready    ),
    .res_o        ( result           ),
    .res_valid_o  ( res_valid_o      ),
    .res_ready_i  ( res_ready_i      )
  );

  assign res_id_o    = result.id;
  assign res_data_o  = result.data;
  assign res_error_o = result.error;

endmodule

`default_nettype wire

/* cc_complex_properties.sv */
`default_nettype none

`include "cc_cfg.svh"

module cc_complex_properties (
  input logic                        clk_i,
  input logic                        rst_i,
  input logic                        res_valid_i,
  input logic                        res_ready_i,
  input logic [`CC_ID_WIDTH-1:0]     res_id_i,
  input logic [`CC_DATA_WIDTH-1:0]   res_data_i,
  input logic                        res_error_i,
  input logic                        qvalid_i,
  input logic                        qready_i,
  input logic [`CC_DATA_WIDTH-1:0]   qaddr_i,
  input logic                        qwrite_i,
  input logic [`CC_DATA_WIDTH-1:0]   qdata_i,
  input logic [`CC_DATA_WIDTH/8-1:0] qstrb_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // A stalled result keeps valid and payload
  a_res_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    res_valid_i && !res_ready_i |=>
      res_valid_i && $stable({res_id_i, res_data_i, res_error_i}))
    else $error("result changed before it was accepted");

  a_tcdm_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    qvalid_i && !qready_i |=>
      qvalid_i && $stable({qaddr_i, qwrite_i, qdata_i, qstrb_i}))
    else $error("TCDM request changed before it was accepted");

  a_reset_quiet: assert property (@(posedge clk_i)
    rst_i |-> !res_valid_i && !qvalid_i)
    else $error("valid output high during reset");

endmodule

bind cc_complex cc_complex_properties i_props (
  .clk_i       ( clk_i         ),
  .rst_i       ( rst_i         ),
  .res_valid_i ( res_valid_o   ),
  .res_ready_i ( res_ready_i   ),
  .res_id_i    ( res_id_o      ),
  .res_data_i  ( res_data_o    ),
  .res_error_i ( res_error_o   ),
  .qvalid_i    ( data_qvalid_o ),
  .qready_i    ( data_qready_i ),
  .qaddr_i     ( data_qaddr_o  ),
  .qwrite_i    ( data_qwrite_o ),
  .qdata_i     ( data_qdata_o  ),
  .qstrb_i     ( data_qstrb_o  )
);

`default_nettype wire

/* cc_dispatch.sv */
`default_nettype none

module cc_dispatch (
  input  cc_pkg::op_req_t  op_i,
  input  logic             op_valid_i,
  output logic             op_ready_o,
  output cc_pkg::acc_req_t acc_req_o,
  output logic             acc_valid_o,
  input  logic             acc_ready_i,
  output cc_pkg::dreq_t    data_req_o,
  output logic             data_valid_o,
  input  logic             data_ready_i
);

  import cc_pkg::*;

  logic is_store;
  logic is_mem;

  assign is_store = op_i.op == STORE;
  assign is_mem   = is_store || (op_i.op == LOAD);

  // Exactly one path sees the operation
  assign acc_valid_o  = op_valid_i && !is_mem;
  assign data_valid_o = op_valid_i && is_mem;
  assign op_ready_o   = is_mem ? data_ready_i : acc_ready_i;

  assign acc_req_o.id   = op_i.id;
  assign acc_req_o.op   = op_i.op;
  assign acc_req_o.arga = op_i.arga;
  assign acc_req_o.argb = op_i.argb;

  // Byte address in arga, store data in argb
  assign data_req_o.id    = op_i.id;
  assign data_req_o.addr  = op_i.arga;
  assign data_req_o.write = is_store;
  assign data_req_o.data  = is_store ? op_i.argb : '0;
  assign data_req_o.strb  = {$bits(strb_t){is_store}};

endmodule

`default_nettype wire

/* cc_ipu.sv */
`default_nettype none

`include "cc_cfg.svh"

module cc_ipu (
  input  logic              clk_i,
  input  logic              rst_i,
  input  cc_pkg::acc_req_t  acc_req_i,
  input  logic              acc_valid_i,
  output logic              acc_ready_o,
  output cc_pkg::acc_resp_t acc_resp_o,
  output logic              acc_valid_o,
  input  logic              acc_ready_i
);

  import cc_pkg::*;

  localparam int unsigned W = `CC_DATA_WIDTH;

  typedef enum logic [1:0] {
    S_IDLE,
    S_DIV,
    S_DONE
  } state_e;

  state_e state_q;
  id_t    id_q;
  data_t  result_q;
  logic   accept;
  logic   is_div;

  logic signed [2*W-1:0] product;

  data_t              divisor_q, quot_q, rem_q;
  logic               is_rem_q, neg_quot_q, neg_rem_q;
  logic [$clog2(W):0] cnt_q;
  logic [W:0]         rem_shift;
  logic               sub_ok;
  data_t              quot_fix, rem_fix;

  assign accept  = acc_valid_i && acc_ready_o;
  assign is_div  = acc_req_i.op inside {DIV, REM};
  assign product = $signed(acc_req_i.arga) * $signed(acc_req_i.argb);

  // --------------------------------------------------------------------------
  // Restoring divider on magnitudes, one quotient bit per cycle
  // --------------------------------------------------------------------------
  assign rem_shift = {rem_q, quot_q[W-1]};
  assign sub_ok    = rem_shift >= {1'b0, divisor_q};
  assign quot_fix  = neg_quot_q ? -quot_q : quot_q;
  assign rem_fix   = neg_rem_q ? -rem_q : rem_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (accept) begin
            state_q <= is_div ? S_DIV : S_DONE;
            cnt_q   <= '0;
          end
        end
        S_DIV: begin
          if (cnt_q == W) begin
            state_q <= S_DONE;
          end
          cnt_q <= cnt_q + 1'b1;
        end
        S_DONE: begin
          if (acc_ready_i) begin
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Divide by zero leaves an all-ones quotient and the dividend magnitude as
  // remainder, so only the quotient sign flip has to be suppressed. The
  // overflow case comes out of the magnitudes unchanged
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q <= acc_req_i.id;
      if (is_div) begin
        is_rem_q   <= acc_req_i.op == REM;
        neg_quot_q <= (acc_req_i.arga[W-1] ^ acc_req_i.argb[W-1]) && (acc_req_i.argb != '0);
        neg_rem_q  <= acc_req_i.arga[W-1];
        quot_q     <= acc_req_i.arga[W-1] ? -acc_req_i.arga : acc_req_i.arga;
        divisor_q  <= acc_req_i.argb[W-1] ? -acc_req_i.argb : acc_req_i.argb;
        rem_q      <= '0;
      end else begin
        result_q <= (acc_req_i.op == MULH) ? product[2*W-1:W] : product[W-1:0];
      end
    end else if (state_q == S_DIV) begin
      if (cnt_q == W) begin
        result_q <= is_rem_q ? rem_fix : quot_fix;
      end else begin
        quot_q <= {quot_q[W-2:0], sub_ok};
        rem_q  <= sub_ok ? rem_shift[W-1:0] - divisor_q : rem_shift[W-1:0];
      end
    end
  end

  assign acc_ready_o      = state_q == S_IDLE;
  assign acc_valid_o      = state_q == S_DONE;
  assign acc_resp_o.id    = id_q;
  assign acc_resp_o.data  = result_q;
  assign acc_resp_o.error = 1'b0;

endmodule

`default_nettype wire

/* cc_lsu.sv */
`default_nettype none

`include "cc_cfg.svh"

module cc_lsu (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  cc_pkg::dreq_t                req_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  output logic [`CC_DATA_WIDTH-1:0]    data_qaddr_o,
  output logic                         data_qwrite_o,
  output logic [`CC_DATA_WIDTH-1:0]    data_qdata_o,
  output logic [`CC_DATA_WIDTH/8-1:0]  data_qstrb_o,
  output logic                         data_qvalid_o,
  input  logic                         data_qready_i,
  input  logic [`CC_DATA_WIDTH-1:0]    data_pdata_i,
  input  logic                         data_perror_i,
  input  logic                         data_pvalid_i,
  output logic                         data_pready_o,
  output cc_pkg::dresp_t               resp_o,
  output logic                         resp_valid_o,
  input  logic                         resp_ready_i
);

  import cc_pkg::*;

  localparam int unsigned Depth = `CC_LSU_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;

  id_t             id_mem [Depth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrW:0]   count_q;
  logic            full, push, pop;

  // Request side, stalls once every slot holds an outstanding id
  assign full          = count_q == Depth;
  assign data_qvalid_o = req_valid_i && !full;
  assign req_ready_o   = data_qready_i && !full;
  assign data_qaddr_o  = req_i.addr;
  assign data_qwrite_o = req_i.write;
  assign data_qdata_o  = req_i.data;
  assign data_qstrb_o  = req_i.strb;

  // In-order responses take the oldest id
  assign resp_valid_o  = data_pvalid_i;
  assign data_pready_o = resp_ready_i;
  assign resp_o.id     = id_mem[rd_ptr_q];
  assign resp_o.data   = data_pdata_i;
  assign resp_o.error  = data_perror_i;

  assign push = data_qvalid_o && data_qready_i;
  assign pop  = resp_valid_o && resp_ready_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      id_mem[wr_ptr_q] <= req_i.id;
    end
  end

endmodule

`default_nettype wire

/* cc_pkg.sv */
`default_nettype none

`include "cc_cfg.svh"

package cc_pkg;

  typedef enum logic [2:0] {
    MUL   = 3'd0,
    MULH  = 3'd1,
    DIV   = 3'd2,
    REM   = 3'd3,
    LOAD  = 3'd4,
    STORE = 3'd5
  } op_e;

  typedef logic [`CC_DATA_WIDTH-1:0]   data_t;
  typedef logic [`CC_ID_WIDTH-1:0]     id_t;
  typedef logic [`CC_DATA_WIDTH/8-1:0] strb_t;

  // Operation as it enters the complex
  typedef struct packed {
    op_e   op;
    id_t   id;
    data_t arga;
    data_t argb;
  } op_req_t;

  // Offload path
  typedef struct packed {
    id_t   id;
    op_e   op;
    data_t arga;
    data_t argb;
  } acc_req_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    logic  error;
  } acc_resp_t;

  // Memory path
  typedef struct packed {
    id_t   id;
    data_t addr;
    logic  write;
    data_t data;
    strb_t strb;
  } dreq_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    logic  error;
  } dresp_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    logic  error;
  } result_t;

endpackage

`default_nettype wire

/* cc_writeback.sv */
`default_nettype none

module cc_writeback (
  input  logic              clk_i,
  input  logic              rst_i,
  input  cc_pkg::acc_resp_t acc_resp_i,
  input  logic              acc_valid_i,
  output logic              acc_ready_o,
  input  cc_pkg::dresp_t    data_resp_i,
  input  logic              data_valid_i,
  output logic              data_ready_o,
  output cc_pkg::result_t   res_o,
  output logic              res_valid_o,
  input  logic              res_ready_i
);

  import cc_pkg::*;

  logic prio_q;  // set when the data path wins a tie
  logic lock_q, lock_sel_q;
  logic arb_data, sel_data;

  assign arb_data = data_valid_i && (!acc_valid_i || prio_q);

  // A stalled result keeps its source until taken
  assign sel_data = lock_q ? lock_sel_q : arb_data;

  assign res_valid_o  = acc_valid_i || data_valid_i;
  assign res_o.id     = sel_data ? data_resp_i.id : acc_resp_i.id;
  assign res_o.data   = sel_data ? data_resp_i.data : acc_resp_i.data;
  assign res_o.error  = sel_data ? data_resp_i.error : acc_resp_i.error;
  assign acc_ready_o  = res_ready_i && !sel_data;
  assign data_ready_o = res_ready_i && sel_data;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      prio_q     <= 1'b0;
      lock_q     <= 1'b0;
      lock_sel_q <= 1'b0;
    end else begin
      lock_q     <= res_valid_o && !res_ready_i;
      lock_sel_q <= sel_data;
      if (res_valid_o && res_ready_i) begin
        prio_q <= !sel_data;
      end
    end
  end

endmodule

`default_nettype wire

/* spill_register.sv */
`default_nettype none

module spill_register #(
  parameter type T      = logic,
  parameter bit  Bypass = 1'b0
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    T     a_data_q, b_data_q;
    logic a_full_q, b_full_q;
    logic a_fill, a_drain, b_fill, b_drain;

    // Slot A takes new data, slot B catches it when the output stalls
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill) begin
          a_full_q <= 1'b1;
        end else if (a_drain) begin
          a_full_q <= 1'b0;
        end
        if (b_fill) begin
          b_full_q <= 1'b1;
        end else if (b_drain) begin
          b_full_q <= 1'b0;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // B always holds the older item
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;
  end

endmodule

`default_nettype wire

/* tb_cc_checker.sv */
`default_nettype none

`include "cc_cfg.svh"

module tb_cc_checker (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [2:0]                op_op_i,
  input  logic [`CC_ID_WIDTH-1:0]   op_id_i,
  input  logic [`CC_DATA_WIDTH-1:0] op_arga_i,
  input  logic [`CC_DATA_WIDTH-1:0] op_argb_i,
  input  logic                      op_valid_i,
  input  logic                      op_ready_i,
  input  logic [`CC_ID_WIDTH-1:0]   res_id_i,
  input  logic [`CC_DATA_WIDTH-1:0] res_data_i,
  input  logic                      res_error_i,
  input  logic                      res_valid_i,
  input  logic                      res_ready_i,
  input  int                        test_idx_i,
  input  logic                      test_end_i,
  output int                        error_count_o,
  output int                        check_count_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import cc_pkg::*;

  localparam int IDS = 1 << `CC_ID_WIDTH;

  logic [31:0] mem [`CC_MEM_WORDS];
  logic [31:0] exp_data [IDS];
  logic        exp_err [IDS];
  logic        pending [IDS];
  int          errors, checks, test_ops, test_checks, test_errors;
  string       names [5] = '{"multiply", "divide", "memory", "errors", "concurrency"};

  assign error_count_o = errors;
  assign check_count_o = checks;

  function automatic logic [31:0] init_word(input int unsigned i);
    return (i * 32'h9e37_79b9) ^ {i[15:0], ~i[15:0]};
  endfunction

  // Signed 64-bit product, low or high half
  function automatic logic [31:0] ref_mul(input logic [31:0] a, input logic [31:0] b,
                                          input logic high);
    longint p;
    p = longint'($signed(a)) * longint'($signed(b));
    return high ? p[63:32] : p[31:0];
  endfunction

  // RISC-V division corner cases first
  function automatic logic [31:0] ref_div(input logic [31:0] a, input logic [31:0] b,
                                          input logic rem);
    int sa;
    int sb;
    sa = a;
    sb = b;
    if (b == 32'h0) return rem ? a : 32'hffff_ffff;
    if (a == 32'h8000_0000 && b == 32'hffff_ffff) return rem ? 32'h0 : a;
    return rem ? sa % sb : sa / sb;
  endfunction

  task automatic record_op();
    logic [31:0] word;
    word = op_arga_i >> 2;
    pending[op_id_i] = 1'b1;
    exp_err[op_id_i] = 1'b0;
    exp_data[op_id_i] = 32'h0;
    test_ops++;
    case (op_op_i)
      MUL:  exp_data[op_id_i] = ref_mul(op_arga_i, op_argb_i, 1'b0);
      MULH: exp_data[op_id_i] = ref_mul(op_arga_i, op_argb_i, 1'b1);
      DIV:  exp_data[op_id_i] = ref_div(op_arga_i, op_argb_i, 1'b0);
      REM:  exp_data[op_id_i] = ref_div(op_arga_i, op_argb_i, 1'b1);
      default: begin
        if (word >= `CC_MEM_WORDS) begin
          exp_err[op_id_i] = 1'b1;
        end else if (op_op_i == STORE) begin
          mem[word] = op_argb_i;
        end else begin
          exp_data[op_id_i] = mem[word];
        end
      end
    endcase
  endtask

  task automatic check_result();
    if (!pending[res_id_i]) begin
      $display("ERROR: result for id %0d arrived with no operation in flight", res_id_i);
      errors++;
      test_errors++;
    end else begin
      pending[res_id_i] = 1'b0;
      checks++;
      test_checks++;
      if (res_data_i !== exp_data[res_id_i] || res_error_i !== exp_err[res_id_i]) begin
        $display("FAIL %s: id %0d expected data %h error %b, actual data %h error %b",
                 names[test_idx_i], res_id_i, exp_data[res_id_i], exp_err[res_id_i],
                 res_data_i, res_error_i);
        errors++;
        test_errors++;
      end
    end
  endtask

  task automatic report_test();
    if (test_checks != test_ops) begin
      $display("ERROR: %s got %0d results for %0d operations", names[test_idx_i],
               test_checks, test_ops);
      errors++;
      test_errors++;
    end
    $display("test %0d %s: %0d results checked, %0d errors", test_idx_i + 1,
             names[test_idx_i], test_checks, test_errors);
    test_ops    = 0;
    test_checks = 0;
    test_errors = 0;
  endtask

  initial begin
    errors      = 0;
    checks      = 0;
    test_ops    = 0;
    test_checks = 0;
    test_errors = 0;
    foreach (mem[i]) mem[i] = init_word(i);
    foreach (pending[i]) pending[i] = 1'b0;
  end

  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (res_valid_i && res_ready_i) check_result();
      if (op_valid_i && op_ready_i) record_op();
      if (test_end_i) report_test();
    end
  end

endmodule

`default_nettype wire

/* tb_cc_complex.sv */
`default_nettype none

`include "cc_cfg.svh"

module tb_cc_complex;

  timeunit 1ns;
  timeprecision 1ps;

  import cc_pkg::*;

  localparam int IDS           = 1 << `CC_ID_WIDTH;
  localparam int NUM_OPS [5]   = '{40, 30, 48, 32, 120};
  localparam int TOTAL_OPS     = NUM_OPS[0] + NUM_OPS[1] + NUM_OPS[2] + NUM_OPS[3] + NUM_OPS[4];
  localparam int WATCHDOG_CYC  = TOTAL_OPS * 40 + 1000;

  logic                        clk_i;
  logic                        rst_i;
  logic [2:0]                  op_op_i;
  logic [`CC_ID_WIDTH-1:0]     op_id_i;
  logic [`CC_DATA_WIDTH-1:0]   op_arga_i, op_argb_i;
  logic                        op_valid_i, op_ready_o;
  logic [`CC_DATA_WIDTH-1:0]   data_qaddr_o, data_qdata_o;
  logic                        data_qwrite_o, data_qvalid_o, data_qready_i;
  logic [`CC_DATA_WIDTH/8-1:0] data_qstrb_o;
  logic [`CC_DATA_WIDTH-1:0]   data_pdata_i;
  logic                        data_perror_i, data_pvalid_i, data_pready_o;
  logic [`CC_ID_WIDTH-1:0]     res_id_o;
  logic [`CC_DATA_WIDTH-1:0]   res_data_o;
  logic                        res_error_o, res_valid_o, res_ready_i;

  logic [31:0]             rng;
  logic [31:0]             mem [`CC_MEM_WORDS];
  logic [32:0]             resp_q [$];
  logic                    busy [IDS];
  logic [`CC_ID_WIDTH-1:0] next_id;
  logic                    op_taken, resp_taken, test_end;
  int                      resp_wait, accepted, test_idx, error_count, check_count;

  cc_complex i_dut (.*);

  tb_cc_checker i_checker (
    .clk_i, .rst_i, .op_op_i, .op_id_i, .op_arga_i, .op_argb_i, .op_valid_i,
    .op_ready_i    ( op_ready_o  ),
    .res_id_i      ( res_id_o    ),
    .res_data_i    ( res_data_o  ),
    .res_error_i   ( res_error_o ),
    .res_valid_i   ( res_valid_o ),
    .res_ready_i,
    .test_idx_i    ( test_idx    ),
    .test_end_i    ( test_end    ),
    .error_count_o ( error_count ),
    .check_count_o ( check_count )
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [31:0] init_word(input int unsigned i);
    return (i * 32'h9e37_79b9) ^ {i[15:0], ~i[15:0]};
  endfunction

  function automatic int find_free_id();
    logic [`CC_ID_WIDTH-1:0] id;
    for (int i = 0; i < IDS; i++) begin
      id = next_id + `CC_ID_WIDTH'(i);
      if (!busy[id]) begin
        next_id = id + 1'b1;
        return int'(id);
      end
    end
    return -1;
  endfunction

  function automatic logic any_busy();
    foreach (busy[i]) if (busy[i]) return 1'b1;
    return 1'b0;
  endfunction

  // --------------------------------------------------------------------------
  // TCDM memory model and handshake bookkeeping
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin : sample
    logic [31:0] word;
    if (!rst_i) begin
      if (data_pvalid_i && data_pready_o) begin
        void'(resp_q.pop_front());
        resp_taken = 1'b1;
      end
      if (data_qvalid_o && data_qready_i) begin
        word = data_qaddr_o >> 2;
        if (word >= `CC_MEM_WORDS) begin
          resp_q.push_back({1'b1, 32'h0});
        end else begin
          for (int k = 0; k < 4; k++)
            if (data_qwrite_o && data_qstrb_o[k]) mem[word][8*k +: 8] = data_qdata_o[8*k +: 8];
          resp_q.push_back({1'b0, data_qwrite_o ? 32'h0 : mem[word]});
        end
      end
      if (op_valid_i && op_ready_o) begin
        busy[op_id_i] = 1'b1;
        op_taken      = 1'b1;
        accepted++;
      end
      if (res_valid_o && res_ready_i) busy[res_id_o] = 1'b0;
    end
  end

  // Random ready, in-order responses after 0 to 3 idle cycles
  task automatic drive_env();
    logic [31:0] r;
    r = rand32();
    data_qready_i = r[1:0] != 2'b00;
    res_ready_i   = r[3:2] != 2'b00;
    if (resp_taken) begin
      data_pvalid_i = 1'b0;
      resp_taken    = 1'b0;
      resp_wait     = int'(r[5:4]);
    end
    if (!data_pvalid_i && resp_q.size() > 0) begin
      if (resp_wait == 0) begin
        {data_perror_i, data_pdata_i} = resp_q[0];
        data_pvalid_i = 1'b1;
      end else begin
        resp_wait--;
      end
    end
  endtask

  task automatic tick();
    @(negedge clk_i);
    drive_env();
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  task automatic gen_op(input int test, input int idx, output logic [2:0] op,
                        output logic [31:0] a, output logic [31:0] b);
    logic [31:0] r, x, y, word;
    logic        in_range;
    r = rand32();
    x = rand32();
    y = rand32();
    case (test)
      0:       op = r[0] ? MULH : MUL;
      1:       op = (idx < 4) ? (idx[0] ? REM : DIV) : (r[0] ? REM : DIV);
      2:       op = (idx < NUM_OPS[2] / 2) ? STORE : LOAD;
      3:       op = r[0] ? STORE : LOAD;
      default: op = 3'(r[7:0] % 6);
    endcase
    a = x;
    b = y;
    if (op == DIV || op == REM) begin
      // First four divides hit division by zero, then overflow
      case ((test == 1 && idx < 4) ? 3'(idx >> 1) : r[3:1])
        3'd0: b = 32'h0;
        3'd1: begin
          a = 32'h8000_0000;
          b = 32'hffff_ffff;
        end
        3'd2: b = {{24{y[31]}}, y[7:0]};
        default: ;
      endcase
    end else if (op == LOAD || op == STORE) begin
      in_range = (test == 3) ? r[4] : (r[5:4] != 2'b00);
      if (test == 2) word = x % 32;
      else if (in_range) word = x % `CC_MEM_WORDS;
      else word = `CC_MEM_WORDS + x % 32'h0001_0000;
      a = word << 2;
    end
  endtask

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic issue_op(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b);
    int id;
    id = find_free_id();
    while (id < 0) begin
      tick();
      id = find_free_id();
    end
    op_op_i    = op;
    op_id_i    = `CC_ID_WIDTH'(id);
    op_arga_i  = a;
    op_argb_i  = b;
    op_valid_i = 1'b1;
    op_taken   = 1'b0;
    do tick(); while (!op_taken);
    op_valid_i = 1'b0;
  endtask

  initial begin
    logic [2:0]  op;
    logic [31:0] a, b;
    clk_i = 1'b0;
    rst_i = 1'b1;
    {op_op_i, op_id_i, op_arga_i, op_argb_i, op_valid_i} = '0;
    {data_qready_i, data_pdata_i, data_perror_i, data_pvalid_i, res_ready_i} = '0;
    rng        = 32'h5015;
    next_id    = '0;
    op_taken   = 1'b0;
    resp_taken = 1'b0;
    resp_wait  = 0;
    accepted   = 0;
    test_idx   = 0;
    test_end   = 1'b0;
    foreach (mem[i]) mem[i] = init_word(i);
    foreach (busy[i]) busy[i] = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    for (int t = 0; t < 5; t++) begin
      test_idx = t;
      for (int n = 0; n < NUM_OPS[t]; n++) begin
        gen_op(t, n, op, a, b);
        issue_op(op, a, b);
      end
      while (any_busy()) tick();
      test_end = 1'b1;
      tick();
      test_end = 1'b0;
    end
    $display("Summary: %0d operations accepted, %0d results checked, %0d errors",
             accepted, check_count, error_count);
    if (error_count == 0 && check_count == TOTAL_OPS && accepted == TOTAL_OPS) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge clk_i);
    $display("Timeout: run still busy after %0d cycles, %0d results checked",
             WATCHDOG_CYC, check_count);
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire
